//--- src/cache_cfg_pkg.sv
`default_nettype none

package cache_cfg_pkg;

  // word address width seen on both buses
  localparam int ADR_W = 25;
  localparam int DAT_W = 32;

  // two low address bits pick the word within a line
  localparam int WORD_SEL_W = 2;
  localparam int WORDS = 1 << WORD_SEL_W;

  // the tag field is sized for the default index width
  localparam int DEF_IDX_W = 8;
  localparam int DEF_TAG_W = ADR_W - DEF_IDX_W - WORD_SEL_W;

  typedef logic [WORDS-1:0][DAT_W-1:0] line_words_t;

  // one dirty bit per word so a flush writes back only modified words
  typedef struct packed {
    logic                 valid;
    logic [WORDS-1:0]     dirty;
    logic [DEF_TAG_W-1:0] tag;
  } tag_state_t;

endpackage

`default_nettype wire

//--- src/wb_pkg.sv
`default_nettype none

package wb_pkg;

  typedef struct packed {
    logic                                  cyc;
    logic                                  stb;
    logic                                  we;
    logic [cache_cfg_pkg::ADR_W-1:0]       adr;
    logic [cache_cfg_pkg::DAT_W/8-1:0]     sel;
    logic [cache_cfg_pkg::DAT_W-1:0]       dat;
  } wb_req_t;

  typedef struct packed {
    logic                                  ack;
    logic [cache_cfg_pkg::DAT_W-1:0]       dat;
  } wb_rsp_t;

  typedef enum logic {FLUSH, FILL} xfer_op_e;

  // base is the address of word 0 of the line being moved
  typedef struct packed {
    logic                                  start;
    xfer_op_e                              op;
    logic [cache_cfg_pkg::ADR_W-1:0]       base;
    cache_cfg_pkg::line_words_t            words;
    logic [cache_cfg_pkg::WORDS-1:0]       dirty;
  } xfer_req_t;

  typedef struct packed {
    logic                                  done;
    cache_cfg_pkg::line_words_t            words;
  } xfer_rsp_t;

endpackage

`default_nettype wire

//--- src/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store #(
  parameter int  DEPTH_W = 8,
  parameter type entry_t = logic [31:0]
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic [DEPTH_W-1:0] addr_i,
  input  logic               we_i,
  input  entry_t             wdata_i,
  output entry_t             rdata_o
);

  entry_t mem [2**DEPTH_W];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // a read in the same cycle as a write to that entry returns the old contents
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rdata_o <= '0;
    end else begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

//--- src/line_mover.sv
`timescale 1ns/1ps
`default_nettype none

module line_mover (
  input  logic              clk_i,
  input  logic              rst_i,
  input  wb_pkg::xfer_req_t xfer_req_i,
  output wb_pkg::xfer_rsp_t xfer_rsp_o,
  output wb_pkg::wb_req_t   m_req_o,
  input  wb_pkg::wb_rsp_t   m_rsp_i
);

  import cache_cfg_pkg::*;
  import wb_pkg::*;

  typedef enum logic [1:0] {M_IDLE, M_ISSUE, M_GAP} mstate_e;

  mstate_e               state_q;
  logic [WORD_SEL_W-1:0] cnt_q;
  logic                  done_q;
  line_words_t           line_q;
  logic [WORDS-1:0]      need;
  logic [WORD_SEL_W:0]   first_idx;
  logic [WORD_SEL_W:0]   next_idx;

  // lowest word at or above from that needs a transfer, the top bit set means none
  function automatic logic [WORD_SEL_W:0] first_from(input logic [WORDS-1:0] mask,
                                                     input logic [WORD_SEL_W:0] from);
    logic [WORD_SEL_W:0] idx;
    idx = (WORD_SEL_W+1)'(WORDS);
    for (int i = WORDS - 1; i >= 0; i--) begin
      if (mask[i] && i >= int'(from)) begin
        idx = (WORD_SEL_W+1)'(i);
      end
    end
    return idx;
  endfunction

  assign need      = (xfer_req_i.op == FILL) ? '1 : xfer_req_i.dirty;
  assign first_idx = first_from(need, '0);
  assign next_idx  = first_from(need, {1'b0, cnt_q} + (WORD_SEL_W+1)'(1));

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= M_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        M_IDLE: begin
          if (xfer_req_i.start && first_idx[WORD_SEL_W]) begin
            done_q <= 1'b1;
          end else if (xfer_req_i.start) begin
            cnt_q   <= first_idx[WORD_SEL_W-1:0];
            state_q <= M_ISSUE;
          end
        end
        M_ISSUE: begin
          if (m_rsp_i.ack && next_idx[WORD_SEL_W]) begin
            done_q  <= 1'b1;
            state_q <= M_IDLE;
          end else if (m_rsp_i.ack) begin
            cnt_q   <= next_idx[WORD_SEL_W-1:0];
            state_q <= M_GAP;
          end
        end
        M_GAP:   state_q <= M_ISSUE;
        default: state_q <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == M_ISSUE && m_rsp_i.ack && xfer_req_i.op == FILL) begin
      line_q[cnt_q] <= m_rsp_i.dat;
    end
  end

  always_comb begin
    m_req_o.cyc = (state_q == M_ISSUE);
    m_req_o.stb = (state_q == M_ISSUE);
    m_req_o.we  = (xfer_req_i.op == FLUSH);
    m_req_o.adr = {xfer_req_i.base[ADR_W-1:WORD_SEL_W], cnt_q};
    m_req_o.sel = '1;
    m_req_o.dat = xfer_req_i.words[cnt_q];
  end

  assign xfer_rsp_o.done  = done_q;
  assign xfer_rsp_o.words = line_q;

endmodule

`default_nettype wire

//--- src/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
  parameter int IDX_W = 8
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  wb_pkg::wb_req_t            s_req_i,
  output wb_pkg::wb_rsp_t            s_rsp_o,
  output logic                       hit_o,
  output logic [IDX_W-1:0]           tag_addr_o,
  output logic                       tag_we_o,
  output cache_cfg_pkg::tag_state_t  tag_wdata_o,
  input  cache_cfg_pkg::tag_state_t  tag_rdata_i,
  output logic [IDX_W-1:0]           data_addr_o,
  output logic                       data_we_o,
  output cache_cfg_pkg::line_words_t data_wdata_o,
  input  cache_cfg_pkg::line_words_t data_rdata_i,
  output wb_pkg::xfer_req_t          xfer_req_o,
  input  wb_pkg::xfer_rsp_t          xfer_rsp_i
);

  import cache_cfg_pkg::*;
  import wb_pkg::*;

  // index widths below the default would need a wider tag field
  localparam int TAG_W = ADR_W - IDX_W - WORD_SEL_W;

  typedef enum logic [2:0] {
    S_INIT, S_IDLE, S_READ, S_COMPARE, S_XFER, S_FILL_WR, S_ACK
  } state_e;

  state_e                state_q;
  logic [IDX_W-1:0]      init_cnt_q;
  logic                  missed_q;
  logic                  start_q;
  xfer_op_e              op_q;
  wb_req_t               req_q;
  tag_state_t            ts_q;
  line_words_t           line_q;
  logic [DAT_W-1:0]      rdata_q;

  logic [TAG_W-1:0]      req_tag;
  logic [IDX_W-1:0]      req_idx;
  logic [WORD_SEL_W-1:0] req_word;
  logic [IDX_W-1:0]      store_idx;
  logic                  hit;
  logic                  need_flush;
  logic [DAT_W-1:0]      merged_word;
  tag_state_t            fill_ts;

  assign req_tag  = req_q.adr[ADR_W-1 -: TAG_W];
  assign req_idx  = req_q.adr[WORD_SEL_W +: IDX_W];
  assign req_word = req_q.adr[WORD_SEL_W-1:0];

  assign hit        = ts_q.valid && (ts_q.tag == DEF_TAG_W'(req_tag));
  assign need_flush = ts_q.valid && (|ts_q.dirty);
  assign fill_ts    = '{valid: 1'b1, dirty: '0, tag: DEF_TAG_W'(req_tag)};

  always_comb begin
    merged_word = line_q[req_word];
    for (int b = 0; b < DAT_W / 8; b++) begin
      if (req_q.sel[b]) begin
        merged_word[8*b +: 8] = req_q.dat[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= S_INIT;
      init_cnt_q <= '0;
      missed_q   <= 1'b0;
      start_q    <= 1'b0;
      op_q       <= FILL;
    end else begin
      start_q <= 1'b0;
      case (state_q)
        S_INIT: begin
          init_cnt_q <= init_cnt_q + IDX_W'(1);
          if (&init_cnt_q) begin
            state_q <= S_IDLE;
          end
        end
        S_IDLE: begin
          if (s_req_i.cyc && s_req_i.stb) begin
            missed_q <= 1'b0;
            state_q  <= S_READ;
          end
        end
        S_READ: state_q <= S_COMPARE;
        S_COMPARE: begin
          if (hit) begin
            state_q <= S_ACK;
          end else begin
            // the old line goes out first when it holds modified words
            missed_q <= 1'b1;
            start_q  <= 1'b1;
            op_q     <= need_flush ? FLUSH : FILL;
            state_q  <= S_XFER;
          end
        end
        S_XFER: begin
          if (xfer_rsp_i.done) begin
            if (op_q == FLUSH) begin
              start_q <= 1'b1;
              op_q    <= FILL;
            end else begin
              state_q <= S_FILL_WR;
            end
          end
        end
        S_FILL_WR: state_q <= S_COMPARE;
        S_ACK:     state_q <= S_IDLE;
        default:   state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_q)
      S_IDLE: begin
        if (s_req_i.cyc && s_req_i.stb) begin
          req_q <= s_req_i;
        end
      end
      S_READ: begin
        ts_q   <= tag_rdata_i;
        line_q <= data_rdata_i;
      end
      S_COMPARE: begin
        if (hit && req_q.we) begin
          line_q[req_word]     <= merged_word;
          ts_q.dirty[req_word] <= 1'b1;
        end else if (hit) begin
          rdata_q <= line_q[req_word];
        end
      end
      S_XFER: begin
        if (xfer_rsp_i.done && op_q == FILL) begin
          line_q <= xfer_rsp_i.words;
          ts_q   <= fill_ts;
        end
      end
      default: ;
    endcase
  end

  // the index comes straight from the bus while idle so the read starts in cycle 0
  always_comb begin
    store_idx    = req_idx;
    tag_we_o     = 1'b0;
    data_we_o    = 1'b0;
    tag_wdata_o  = ts_q;
    data_wdata_o = line_q;
    case (state_q)
      S_INIT: begin
        store_idx   = init_cnt_q;
        tag_we_o    = 1'b1;
        tag_wdata_o = '0;
      end
      S_IDLE: store_idx = s_req_i.adr[WORD_SEL_W +: IDX_W];
      S_FILL_WR: begin
        tag_we_o  = 1'b1;
        data_we_o = 1'b1;
      end
      S_ACK: begin
        tag_we_o  = req_q.we;
        data_we_o = req_q.we;
      end
      default: ;
    endcase
  end

  assign tag_addr_o  = store_idx;
  assign data_addr_o = store_idx;

  always_comb begin
    s_rsp_o.ack      = (state_q == S_ACK);
    s_rsp_o.dat      = rdata_q;
    xfer_req_o.start = start_q;
    xfer_req_o.op    = op_q;
    xfer_req_o.words = line_q;
    xfer_req_o.dirty = ts_q.dirty;
    if (op_q == FLUSH) begin
      xfer_req_o.base = {ts_q.tag[TAG_W-1:0], req_idx, WORD_SEL_W'(0)};
    end else begin
      xfer_req_o.base = {req_tag, req_idx, WORD_SEL_W'(0)};
    end
  end

  assign hit_o = (state_q == S_ACK) && !missed_q;

endmodule

`default_nettype wire

//--- src/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
  parameter int IDX_W = 8
) (
  input  logic            clk_i,
  input  logic            rst_i,
  input  wb_pkg::wb_req_t s_req_i,
  output wb_pkg::wb_rsp_t s_rsp_o,
  output logic            hit_o,
  output wb_pkg::wb_req_t m_req_o,
  input  wb_pkg::wb_rsp_t m_rsp_i
);

  import cache_cfg_pkg::*;
  import wb_pkg::*;

  logic [IDX_W-1:0] tag_addr;
  logic             tag_we;
  tag_state_t       tag_wdata;
  tag_state_t       tag_rdata;
  logic [IDX_W-1:0] data_addr;
  logic             data_we;
  line_words_t      data_wdata;
  line_words_t      data_rdata;
  xfer_req_t        xfer_req;
  xfer_rsp_t        xfer_rsp;

  cache_ctrl #(
    .IDX_W(IDX_W)
  ) ctrl_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .s_req_i     (s_req_i),
    .s_rsp_o     (s_rsp_o),
    .hit_o       (hit_o),
    .tag_addr_o  (tag_addr),
    .tag_we_o    (tag_we),
    .tag_wdata_o (tag_wdata),
    .tag_rdata_i (tag_rdata),
    .data_addr_o (data_addr),
    .data_we_o   (data_we),
    .data_wdata_o(data_wdata),
    .data_rdata_i(data_rdata),
    .xfer_req_o  (xfer_req),
    .xfer_rsp_i  (xfer_rsp)
  );

  line_store #(
    .DEPTH_W(IDX_W),
    .entry_t(tag_state_t)
  ) tag_store_i (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .addr_i (tag_addr),
    .we_i   (tag_we),
    .wdata_i(tag_wdata),
    .rdata_o(tag_rdata)
  );

  line_store #(
    .DEPTH_W(IDX_W),
    .entry_t(line_words_t)
  ) data_store_i (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .addr_i (data_addr),
    .we_i   (data_we),
    .wdata_i(data_wdata),
    .rdata_o(data_rdata)
  );

  line_mover mover_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .xfer_req_i(xfer_req),
    .xfer_rsp_o(xfer_rsp),
    .m_req_o   (m_req_o),
    .m_rsp_i   (m_rsp_i)
  );

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset drops just after the last reset edge, like any other driven input
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model (
  input  logic            clk_i,
  input  logic            rst_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o
);

  import cache_cfg_pkg::*;
  import wb_pkg::*;

  // only written words are stored, everything else reads as the preload pattern
  logic [DAT_W-1:0] mem [logic [ADR_W-1:0]];
  logic             busy_q;
  logic             ack_q;
  logic [1:0]       wait_q;
  logic [DAT_W-1:0] dat_q;

  function automatic logic [DAT_W-1:0] read_word(input logic [ADR_W-1:0] adr);
    if (mem.exists(adr)) begin
      return mem[adr];
    end
    return {{(DAT_W - ADR_W){1'b0}}, adr} ^ 32'h5a5a0000;
  endfunction

  always @(posedge clk_i or posedge rst_i) begin : ack_seq
    logic [DAT_W-1:0] word;
    if (rst_i) begin
      busy_q <= 1'b0;
      ack_q  <= 1'b0;
      wait_q <= 2'd0;
      dat_q  <= '0;
    end else begin
      ack_q <= 1'b0;
      if (ack_q) begin
        busy_q <= 1'b0;
      end else if (!busy_q && req_i.cyc && req_i.stb) begin
        busy_q <= 1'b1;
        wait_q <= 2'($urandom % 4);
      end else if (busy_q && wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
      end else if (busy_q) begin
        ack_q <= 1'b1;
        word = read_word(req_i.adr);
        if (req_i.we) begin
          for (int b = 0; b < DAT_W / 8; b++) begin
            if (req_i.sel[b]) begin
              word[8*b +: 8] = req_i.dat[8*b +: 8];
            end
          end
          mem[req_i.adr] = word;
        end else begin
          dat_q <= word;
        end
      end
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = dat_q;

endmodule

`default_nettype wire

//--- bench/cache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cache_checker (
  input logic            clk_i,
  input logic            rst_i,
  input wb_pkg::wb_rsp_t s_rsp_i,
  input wb_pkg::wb_req_t m_req_i,
  input wb_pkg::wb_rsp_t m_rsp_i
);

  int fail_cnt = 0;

  ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
    s_rsp_i.ack |=> !s_rsp_i.ack)
    else begin
      $error("requester ack stayed high for two cycles");
      fail_cnt++;
    end

  stb_tracks_cyc: assert property (@(posedge clk_i) m_req_i.stb == m_req_i.cyc)
    else begin
      $error("memory port stb differs from cyc");
      fail_cnt++;
    end

  // a classic master keeps the cycle and its fields until the slave acks
  req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (m_req_i.cyc && !m_rsp_i.ack) |=>
      (m_req_i.cyc && $stable(m_req_i.we) && $stable(m_req_i.adr) &&
       $stable(m_req_i.sel) && $stable(m_req_i.dat)))
    else begin
      $error("memory port request changed while waiting for ack");
      fail_cnt++;
    end

  cyc_in_reset: assert property (@(posedge clk_i) rst_i |-> !m_req_i.cyc)
    else begin
      $error("memory port cyc high during reset");
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- bench/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

  import cache_cfg_pkg::*;
  import wb_pkg::*;

  localparam int IDX_W       = 8;
  localparam int TAG_W       = ADR_W - IDX_W - WORD_SEL_W;
  localparam int N_DIR       = 11;
  localparam int N_RAND      = 24;
  localparam int NUM_ROWS    = N_DIR + N_RAND;
  localparam int IDLE_CHECKS = 8;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 40 + 300 + IDLE_CHECKS;

  typedef struct packed {
    logic             we;
    logic [ADR_W-1:0] adr;
    logic [3:0]       sel;
    logic [DAT_W-1:0] dat;
    logic             exp_hit;
  } row_t;

  // index 0x10 gets loaded, merged, then evicted by tag 1 and reloaded
  localparam row_t DIRECTED [N_DIR] = '{
    '{1'b0, 25'h0000041, 4'hf,    32'h0000_0000, 1'b0},
    '{1'b0, 25'h0000042, 4'hf,    32'h0000_0000, 1'b1},
    '{1'b1, 25'h0000041, 4'b0101, 32'hdead_beef, 1'b1},
    '{1'b0, 25'h0000041, 4'hf,    32'h0000_0000, 1'b1},
    '{1'b1, 25'h0000043, 4'b1000, 32'h1122_3344, 1'b1},
    '{1'b0, 25'h0000043, 4'hf,    32'h0000_0000, 1'b1},
    '{1'b0, 25'h0000441, 4'hf,    32'h0000_0000, 1'b0},
    '{1'b0, 25'h0000041, 4'hf,    32'h0000_0000, 1'b0},
    '{1'b0, 25'h0000043, 4'hf,    32'h0000_0000, 1'b1},
    '{1'b1, 25'h01abc07, 4'b0011, 32'hcafe_f00d, 1'b0},
    '{1'b0, 25'h01abc07, 4'hf,    32'h0000_0000, 1'b1}
  };

  logic    clk;
  logic    rst;
  wb_req_t s_req;
  wb_rsp_t s_rsp;
  logic    hit;
  wb_req_t m_req;
  wb_rsp_t m_rsp;

  row_t             rows [NUM_ROWS];
  int               exp_rd [NUM_ROWS];
  int               exp_wr [NUM_ROWS];
  logic [DAT_W-1:0] shadow [logic [ADR_W-1:0]];
  logic             m_valid [2**IDX_W];
  logic [TAG_W-1:0] m_tag [2**IDX_W];
  logic [WORDS-1:0] m_dirty [2**IDX_W];

  int errors     = 0;
  int mon_errors = 0;
  int mem_rd_cnt = 0;
  int mem_wr_cnt = 0;
  int tests_ok   = 0;
  int tests_bad  = 0;
  int chk_fails;

  clock_gen clk_gen_i (
    .clk_o(clk),
    .rst_o(rst)
  );

  cache_top #(
    .IDX_W(IDX_W)
  ) cache_top_i (
    .clk_i  (clk),
    .rst_i  (rst),
    .s_req_i(s_req),
    .s_rsp_o(s_rsp),
    .hit_o  (hit),
    .m_req_o(m_req),
    .m_rsp_i(m_rsp)
  );

  mem_model mem_i (
    .clk_i(clk),
    .rst_i(rst),
    .req_i(m_req),
    .rsp_o(m_rsp)
  );

  bind cache_top cache_checker chk_i (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .s_rsp_i(s_rsp_o),
    .m_req_i(m_req_o),
    .m_rsp_i(m_rsp_i)
  );

  function automatic logic [DAT_W-1:0] preload_word(input logic [ADR_W-1:0] adr);
    return {{(DAT_W - ADR_W){1'b0}}, adr} ^ 32'h5a5a0000;
  endfunction

  // the value a coherent memory would hold after every completed write
  function automatic logic [DAT_W-1:0] expected_word(input logic [ADR_W-1:0] adr);
    if (shadow.exists(adr)) begin
      return shadow[adr];
    end
    return preload_word(adr);
  endfunction

  function automatic logic [DAT_W-1:0] merge_bytes(input logic [DAT_W-1:0] old_w,
                                                   input logic [DAT_W-1:0] new_w,
                                                   input logic [3:0]       sel);
    logic [DAT_W-1:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic build_table();
    logic [TAG_W-1:0]      tg;
    logic [IDX_W-1:0]      ix;
    logic [WORD_SEL_W-1:0] wd;
    for (int r = 0; r < N_DIR; r++) begin
      rows[r] = DIRECTED[r];
    end
    // three tags over four indices so random traffic keeps evicting lines
    for (int r = N_DIR; r < NUM_ROWS; r++) begin
      tg = TAG_W'($urandom % 3);
      ix = IDX_W'(32'h20 + $urandom % 4);
      wd = WORD_SEL_W'($urandom % 4);
      rows[r].we      = 1'($urandom % 2);
      rows[r].adr     = {tg, ix, wd};
      rows[r].sel     = rows[r].we ? 4'($urandom % 15 + 1) : 4'hf;
      rows[r].dat     = $urandom;
      rows[r].exp_hit = 1'b0;
    end
  endtask

  // direct-mapped write-back model: a miss flushes the dirty words then fills four
  task automatic predict_traffic();
    logic [IDX_W-1:0]      ix;
    logic [TAG_W-1:0]      tg;
    logic [WORD_SEL_W-1:0] wd;
    logic                  is_hit;
    for (int i = 0; i < 2**IDX_W; i++) begin
      m_valid[i] = 1'b0;
      m_tag[i]   = '0;
      m_dirty[i] = '0;
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      ix     = rows[r].adr[WORD_SEL_W +: IDX_W];
      tg     = rows[r].adr[ADR_W-1 -: TAG_W];
      wd     = rows[r].adr[WORD_SEL_W-1:0];
      is_hit = m_valid[ix] && (m_tag[ix] == tg);
      if (r >= N_DIR) begin
        rows[r].exp_hit = is_hit;
      end
      exp_rd[r] = is_hit ? 0 : WORDS;
      exp_wr[r] = (!is_hit && m_valid[ix]) ? $countones(m_dirty[ix]) : 0;
      if (!is_hit) begin
        m_valid[ix] = 1'b1;
        m_tag[ix]   = tg;
        m_dirty[ix] = '0;
      end
      if (rows[r].we) begin
        m_dirty[ix][wd] = 1'b1;
      end
    end
  endtask

  // the first request is already on the bus and has to wait for the init walk
  task automatic check_idle_after_reset();
    int errs0;
    errs0 = errors;
    s_req.cyc = 1'b1;
    s_req.stb = 1'b1;
    s_req.we  = rows[0].we;
    s_req.adr = rows[0].adr;
    s_req.sel = rows[0].sel;
    s_req.dat = rows[0].dat;
    repeat (IDLE_CHECKS) begin
      @(posedge clk);
      #1;
      assert (!m_req.cyc) else begin
        $display("[ERROR] m_req.cyc during the init walk: expected 0x0, got 0x%h",
                 m_req.cyc);
        errors++;
      end
      assert (!s_rsp.ack) else begin
        $display("[ERROR] s_rsp.ack during the init walk: expected 0x0, got 0x%h",
                 s_rsp.ack);
        errors++;
      end
    end
    if (errors == errs0) begin
      tests_ok++;
      $display("test init: buses idle after reset, ok");
    end else begin
      tests_bad++;
      $display("test init: buses idle after reset, errors");
    end
  endtask

  // called 1 ns after a rising edge with no access in flight
  task automatic apply_row(input int r);
    row_t             row;
    int               cycles;
    int               rd0;
    int               wr0;
    int               mon0;
    int               errs0;
    logic [DAT_W-1:0] exp_dat;
    row     = rows[r];
    rd0     = mem_rd_cnt;
    wr0     = mem_wr_cnt;
    mon0    = mon_errors;
    errs0   = errors;
    exp_dat = expected_word(row.adr);
    s_req.cyc = 1'b1;
    s_req.stb = 1'b1;
    s_req.we  = row.we;
    s_req.adr = row.adr;
    s_req.sel = row.sel;
    s_req.dat = row.dat;
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!s_rsp.ack);

    assert (hit == row.exp_hit) else begin
      $display("[ERROR] test %0d hit_o: expected 0x%h, got 0x%h", r, row.exp_hit, hit);
      errors++;
    end
    if (row.exp_hit) begin
      assert (cycles == 3) else begin
        $display("test %0d: hit was acknowledged %0d cycles after acceptance, not 3",
                 r, cycles);
        errors++;
      end
    end
    if (!row.we) begin
      assert (s_rsp.dat == exp_dat) else begin
        $display("[ERROR] test %0d s_rsp.dat at 0x%h: expected 0x%h, got 0x%h",
                 r, row.adr, exp_dat, s_rsp.dat);
        errors++;
      end
    end
    assert (mem_rd_cnt - rd0 == exp_rd[r]) else begin
      $display("[ERROR] test %0d m_req reads: expected 0x%h, got 0x%h",
               r, exp_rd[r], mem_rd_cnt - rd0);
      errors++;
    end
    assert (mem_wr_cnt - wr0 == exp_wr[r]) else begin
      $display("[ERROR] test %0d m_req writes: expected 0x%h, got 0x%h",
               r, exp_wr[r], mem_wr_cnt - wr0);
      errors++;
    end

    if (row.we) begin
      shadow[row.adr] = merge_bytes(exp_dat, row.dat, row.sel);
    end
    if (errors == errs0 && mon_errors == mon0) begin
      tests_ok++;
      $display("test %0d: we=%0b adr=0x%h hit=%0b, ok", r, row.we, row.adr, hit);
    end else begin
      tests_bad++;
      $display("test %0d: we=%0b adr=0x%h hit=%0b, errors", r, row.we, row.adr, hit);
    end
    s_req = '0;
    @(posedge clk);
    #1;
  endtask

  // every word written to memory must carry the latest value of that address
  always @(negedge clk) begin
    if (!rst && m_req.cyc && m_req.stb && m_rsp.ack) begin
      if (m_req.we) begin
        mem_wr_cnt++;
        assert (m_req.dat == expected_word(m_req.adr)) else begin
          $display("[ERROR] m_req.dat at 0x%h: expected 0x%h, got 0x%h",
                   m_req.adr, expected_word(m_req.adr), m_req.dat);
          mon_errors++;
        end
      end else begin
        mem_rd_cnt++;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles without the run ending", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    s_req = '0;
    void'($urandom(32'h0b8a4c44));
    build_table();
    predict_traffic();
    wait (rst === 1'b0);
    check_idle_after_reset();
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(r);
    end
    chk_fails = cache_top_i.chk_i.fail_cnt;
    $display("summary: %0d tests ok, %0d tests with errors, %0d assertion failures",
             tests_ok, tests_bad, chk_fails);
    if (errors == 0 && mon_errors == 0 && chk_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- cache_sys.f
src/cache_cfg_pkg.sv
src/wb_pkg.sv
src/line_store.sv
src/line_mover.sv
src/cache_ctrl.sv
src/cache_top.sv
bench/clock_gen.sv
bench/mem_model.sv
bench/cache_checker.sv
bench/cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module cache_tb -f cache_sys.f -o cache_sim

status=0
./obj_dir/cache_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation reported a failure"
  exit 1
fi
grep -q "Test completed successfully" sim.log
echo "simulation passed"
